//--- masku_params.svh
// Width and sizing macros for the reduced mask unit
// Lane count and lane width together set the 32-bit beat
// VLEN above 64 needs wider counters in the package

`ifndef MASKU_PARAMS_SVH
`define MASKU_PARAMS_SVH

// Number of lanes feeding the unit
`define MASKU_NR_LANES 2

// Bits per lane word
`define MASKU_LANE_W 16

// Largest vl in bits, two full beats
`define MASKU_VLEN 64

// Entries per output queue
`define MASKU_QUEUE_DEPTH 2

// Credits each consumer grants after reset
`define MASKU_CREDITS 2

// Instruction id width
`define MASKU_ID_W 2

`endif

//--- masku_pkg.sv
// Shared types of the mask unit
// Only EW8 and EW16 exist, layout across lanes is sequential

`include "masku_params.svh"

package masku_pkg;

  // Full beat across all lanes
  localparam int unsigned WordW = `MASKU_NR_LANES * `MASKU_LANE_W;
  // One strobe bit per byte of a beat
  localparam int unsigned StrbW = WordW / 8;
  // vl runs from 0 to VLEN inclusive
  localparam int unsigned VlW   = $clog2(`MASKU_VLEN) + 1;
  // EW16 distribution has the most beats, VLEN/2
  localparam int unsigned BeatW = $clog2(`MASKU_VLEN / 2);

  typedef logic [WordW-1:0]       word_t;
  typedef logic [VlW-1:0]         vl_t;
  typedef logic [`MASKU_ID_W-1:0] vid_t;
  // 32 register-file words
  typedef logic [4:0]             vaddr_t;
  typedef logic [StrbW-1:0]       strobe_t;

  // Beat index inside an instruction, and a beat count with one more bit
  typedef logic [BeatW-1:0] beat_t;
  typedef logic [BeatW:0]   bcnt_t;

  typedef enum logic {
    EW8  = 1'b0,
    EW16 = 1'b1
  } sew_e;

  typedef enum logic {
    MASK_MERGE = 1'b0,
    MASK_DIST  = 1'b1
  } mask_op_e;

  typedef struct packed {
    mask_op_e op;
    logic     vm;    // High means unmasked
    sew_e     sew;
    vl_t      vl;
    vaddr_t   vd;
    vid_t     id;
  } mask_req_t;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    word_t  word;
  } result_t;

endpackage

//--- masku_ctrl.sv
// Controller for one instruction at a time
// Operand readys depend on the operand valids in the same cycle
// Only one output queue is active per instruction

`timescale 1ns/1ps

module masku_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  masku_pkg::mask_req_t  req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  logic                  opa_valid_i,
  output logic                  opa_ready_o,
  input  logic                  opb_valid_i,
  output logic                  opb_ready_o,
  input  logic                  opm_valid_i,
  output logic                  opm_ready_o,
  input  logic                  res_full_i,
  input  logic                  strb_full_i,
  input  logic                  res_sent_i,
  input  logic                  strb_sent_i,
  output masku_pkg::mask_req_t  insn_o,
  output masku_pkg::beat_t      beat_o,
  output logic                  res_push_o,
  output logic                  strb_push_o,
  output logic                  m_capture_o,
  output logic                  done_valid_o,
  output masku_pkg::vid_t       done_id_o
);

  masku_pkg::mask_req_t insn_q;
  masku_pkg::beat_t     beat_q;
  masku_pkg::bcnt_t     issue_cnt_q;   // Beats not yet pushed
  masku_pkg::bcnt_t     commit_cnt_q;  // Beats not yet sent
  logic                 busy_q;
  logic                 m_captured_q;
  logic                 is_merge;
  logic                 issuing;
  logic                 merge_ops_ok;

  // Beats per instruction, all element counts per beat are powers of two
  function automatic masku_pkg::bcnt_t beats_of(masku_pkg::mask_req_t r);
    int unsigned sh;
    if (r.op == masku_pkg::MASK_MERGE) begin
      sh = $clog2(masku_pkg::WordW);
    end else if (r.sew == masku_pkg::EW8) begin
      sh = $clog2(masku_pkg::StrbW);
    end else begin
      sh = $clog2(masku_pkg::StrbW / 2);
    end
    return masku_pkg::bcnt_t'((32'(r.vl) + (32'd1 << sh) - 1) >> sh);
  endfunction

  //////////////////////////////////////////////////
  // Issue side
  //////////////////////////////////////////////////

  assign is_merge = (insn_q.op == masku_pkg::MASK_MERGE);
  assign issuing  = busy_q && (issue_cnt_q != '0);

  // a and b always, m only for a masked merge
  assign merge_ops_ok = opa_valid_i && opb_valid_i && (insn_q.vm || opm_valid_i);

  assign res_push_o  = issuing && is_merge && merge_ops_ok && !res_full_i;
  // Distribution waits for the single mask word
  assign m_capture_o = issuing && !is_merge && !m_captured_q && opm_valid_i;
  assign strb_push_o = issuing && !is_merge && m_captured_q && !strb_full_i;

  assign opa_ready_o = res_push_o;
  assign opb_ready_o = res_push_o;
  assign opm_ready_o = is_merge ? (res_push_o && !insn_q.vm) : m_capture_o;

  assign insn_o = insn_q;
  assign beat_o = beat_q;

  //////////////////////////////////////////////////
  // Commit side
  //////////////////////////////////////////////////

  // Every beat has left, the pulse cycle also frees the unit
  assign done_valid_o = busy_q && (commit_cnt_q == '0);
  assign done_id_o    = insn_q.id;
  assign req_ready_o  = !busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_q       <= '0;
      beat_q       <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      busy_q       <= 1'b0;
      m_captured_q <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      insn_q       <= req_i;
      beat_q       <= '0;
      issue_cnt_q  <= beats_of(req_i);
      commit_cnt_q <= beats_of(req_i);
      busy_q       <= 1'b1;
      m_captured_q <= 1'b0;
    end else if (done_valid_o) begin
      busy_q <= 1'b0;
    end else begin
      if (res_push_o || strb_push_o) begin
        issue_cnt_q <= issue_cnt_q - 1'b1;
        beat_q      <= beat_q + 1'b1;
      end
      // Only the active queue can send
      if (res_sent_i || strb_sent_i) begin
        commit_cnt_q <= commit_cnt_q - 1'b1;
      end
      if (m_capture_o) begin
        m_captured_q <= 1'b1;
      end
    end
  end

  // Pushed but unsent beats sit in the active queue, so a send needs one
  a_sent_after_push: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (res_sent_i || strb_sent_i) |-> (commit_cnt_q > issue_cnt_q));

  // Completion is reported once per instruction
  a_done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_valid_o |=> !done_valid_o);

endmodule

//--- mask_merge_alu.sv
// Bitwise a/b merge for one 32-bit beat
// Each beat of a masked merge carries its own mask word

`timescale 1ns/1ps

module mask_merge_alu (
  input  masku_pkg::mask_req_t insn_i,
  input  masku_pkg::beat_t     beat_i,
  input  masku_pkg::word_t     opa_i,
  input  masku_pkg::word_t     opb_i,
  input  masku_pkg::word_t     opm_i,
  output masku_pkg::result_t   result_o
);

  localparam int unsigned WordW = $bits(masku_pkg::word_t);

  masku_pkg::word_t bit_en;

  always_comb begin : p_bit_enable
    int unsigned base;
    // First element of this beat
    base = 32'(beat_i) * WordW;
    for (int unsigned i = 0; i < WordW; i++) begin
      bit_en[i] = (base + i) < 32'(insn_i.vl);
    end
    // Masked instruction also needs the mask bit
    if (!insn_i.vm) begin
      bit_en = bit_en & opm_i;
    end
  end

  // Enabled bits from a, the rest keep the old destination value
  assign result_o.word = (opa_i & bit_en) | (opb_i & ~bit_en);

  // Two words per vector register
  assign result_o.addr = masku_pkg::vaddr_t'(2 * 32'(insn_i.vd) + 32'(beat_i));
  assign result_o.id   = insn_i.id;

endmodule

//--- mask_strobe_expander.sv
// Mask word to per-lane byte strobes, EW8 and EW16 only
// One mask word covers 32 elements, later elements read as unset
// when the instruction is masked

`timescale 1ns/1ps

module mask_strobe_expander (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  masku_pkg::mask_req_t insn_i,
  input  masku_pkg::beat_t     beat_i,
  input  masku_pkg::word_t     opm_i,
  input  logic                 capture_i,
  output masku_pkg::strobe_t   strb_o
);

  localparam int unsigned StrbW = $bits(masku_pkg::strobe_t);
  localparam int unsigned WordW = $bits(masku_pkg::word_t);

  masku_pkg::word_t m_q;

  // Mask word held for the whole distribution
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_q <= '0;
    end else if (capture_i) begin
      m_q <= opm_i;
    end
  end

  //////////////////////////////////////////////////
  // Expansion
  //////////////////////////////////////////////////

  always_comb begin : p_expand
    int unsigned sh;
    int unsigned per_beat;
    int unsigned idx;
    // log2 of bytes per element
    sh       = (insn_i.sew == masku_pkg::EW16) ? 1 : 0;
    per_beat = StrbW >> sh;
    strb_o   = '0;
    // Sequential layout, byte b of the beat belongs to element b >> sh
    // so the lane of element k is k over elements per lane
    for (int unsigned b = 0; b < StrbW; b++) begin
      idx = 32'(beat_i) * per_beat + (b >> sh);
      strb_o[b] = (idx < 32'(insn_i.vl)) &&
                  (insn_i.vm || ((idx < WordW) && m_q[idx % WordW]));
    end
  end

endmodule

//--- credit_queue.sv
// FIFO whose head is released only while the sender holds credits
// Consumer returns at most the credits it was granted
// Writer must not push while full_o is high

`timescale 1ns/1ps

module credit_queue #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 2,
  parameter int unsigned CREDITS   = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  output logic     valid_o,
  output payload_t data_o,
  output logic     sent_o,
  input  logic     credit_i
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH + 1);
  // One spare value so an extra credit shows up
  localparam int unsigned CrdW = $clog2(CREDITS + 2);

  payload_t        mem_q [DEPTH];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic [CrdW-1:0] credit_q;
  logic            send;

  assign full_o  = (count_q == CntW'(DEPTH));
  // One beat per cycle while data and credit are both there
  assign send    = (count_q != '0) && (credit_q != '0);
  assign valid_o = send;
  assign sent_o  = send;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  //////////////////////////////////////////////////
  // Pointers and counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= CrdW'(CREDITS);
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (send) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, send})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
      case ({send, credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: ;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= CntW'(DEPTH));

  // Consumer returned more than it was granted
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CrdW'(CREDITS));

endmodule

//--- masku_top.sv
// Reduced mask unit for a two-lane vector machine
// Sequencer uses valid/ready, both outputs use credits
// One instruction in flight, a new one waits for the done pulse

`timescale 1ns/1ps

`include "masku_params.svh"

module masku_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Sequencer
  input  masku_pkg::mask_req_t req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  output logic                 done_valid_o,
  output masku_pkg::vid_t      done_id_o,
  // Lane operands
  input  masku_pkg::word_t     opa_i,
  input  logic                 opa_valid_i,
  output logic                 opa_ready_o,
  input  masku_pkg::word_t     opb_i,
  input  logic                 opb_valid_i,
  output logic                 opb_ready_o,
  input  masku_pkg::word_t     opm_i,
  input  logic                 opm_valid_i,
  output logic                 opm_ready_o,
  // Results to the register file
  output logic                 res_valid_o,
  output masku_pkg::vid_t      res_id_o,
  output masku_pkg::vaddr_t    res_addr_o,
  output masku_pkg::word_t     res_wdata_o,
  input  logic                 res_credit_i,
  // Strobes to the functional units
  output logic                 strb_valid_o,
  output masku_pkg::strobe_t   strb_o,
  input  logic                 strb_credit_i
);

  masku_pkg::mask_req_t insn;
  masku_pkg::beat_t     beat;
  masku_pkg::result_t   alu_res;
  masku_pkg::result_t   res_head;
  masku_pkg::strobe_t   strb_beat;
  logic                 res_push;
  logic                 res_full;
  logic                 res_sent;
  logic                 strb_push;
  logic                 strb_full;
  logic                 strb_sent;
  logic                 m_capture;

  masku_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .opa_valid_i  (opa_valid_i),
    .opa_ready_o  (opa_ready_o),
    .opb_valid_i  (opb_valid_i),
    .opb_ready_o  (opb_ready_o),
    .opm_valid_i  (opm_valid_i),
    .opm_ready_o  (opm_ready_o),
    .res_full_i   (res_full),
    .strb_full_i  (strb_full),
    .res_sent_i   (res_sent),
    .strb_sent_i  (strb_sent),
    .insn_o       (insn),
    .beat_o       (beat),
    .res_push_o   (res_push),
    .strb_push_o  (strb_push),
    .m_capture_o  (m_capture),
    .done_valid_o (done_valid_o),
    .done_id_o    (done_id_o)
  );

  mask_merge_alu u_alu (
    .insn_i   (insn),
    .beat_i   (beat),
    .opa_i    (opa_i),
    .opb_i    (opb_i),
    .opm_i    (opm_i),
    .result_o (alu_res)
  );

  mask_strobe_expander u_expander (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .insn_i    (insn),
    .beat_i    (beat),
    .opm_i     (opm_i),
    .capture_i (m_capture),
    .strb_o    (strb_beat)
  );

  //////////////////////////////////////////////////
  // Output queues
  //////////////////////////////////////////////////

  credit_queue #(
    .payload_t (masku_pkg::result_t),
    .DEPTH     (`MASKU_QUEUE_DEPTH),
    .CREDITS   (`MASKU_CREDITS)
  ) u_res_queue (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push_i   (res_push),
    .data_i   (alu_res),
    .full_o   (res_full),
    .valid_o  (res_valid_o),
    .data_o   (res_head),
    .sent_o   (res_sent),
    .credit_i (res_credit_i)
  );

  assign res_id_o    = res_head.id;
  assign res_addr_o  = res_head.addr;
  assign res_wdata_o = res_head.word;

  credit_queue #(
    .payload_t (masku_pkg::strobe_t),
    .DEPTH     (`MASKU_QUEUE_DEPTH),
    .CREDITS   (`MASKU_CREDITS)
  ) u_strb_queue (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push_i   (strb_push),
    .data_i   (strb_beat),
    .full_o   (strb_full),
    .valid_o  (strb_valid_o),
    .data_o   (strb_o),
    .sent_o   (strb_sent),
    .credit_i (strb_credit_i)
  );

endmodule

//--- tb_clock_gen.sv
// Testbench clock and reset source
// 8 ns period, reset held low for two rising edges and released on a falling edge

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

  always #4 clk_o = ~clk_o;

endmodule

//--- tb_masku.sv
// Testbench for the mask unit, one golden line per instruction
// Inputs change on the falling edge, outputs are sampled on the falling edge
// Stops at the first wrong value

`timescale 1ns/1ps

`include "masku_params.svh"

module tb_masku;

  localparam int NFIELDS = 20;
  localparam int NLINES  = 9;
  // Cycles that a withheld-credit phase lasts
  localparam int HOLD_CYCLES = 30;

  logic clk_i;
  logic rst_ni;

  masku_pkg::mask_req_t req_i;
  logic                 req_valid_i;
  logic                 req_ready_o;
  logic                 done_valid_o;
  masku_pkg::vid_t      done_id_o;
  masku_pkg::word_t     opa_i;
  masku_pkg::word_t     opb_i;
  masku_pkg::word_t     opm_i;
  logic                 opa_valid_i;
  logic                 opa_ready_o;
  logic                 opb_valid_i;
  logic                 opb_ready_o;
  logic                 opm_valid_i;
  logic                 opm_ready_o;
  logic                 res_valid_o;
  logic                 res_credit_i;
  logic                 strb_valid_o;
  logic                 strb_credit_i;
  masku_pkg::vid_t      res_id_o;
  masku_pkg::vaddr_t    res_addr_o;
  masku_pkg::word_t     res_wdata_o;
  masku_pkg::strobe_t   strb_o;

  logic [31:0] golden [NLINES*NFIELDS];

  // Expected beats in arrival order
  logic [31:0] exp_word_q [$];
  logic [31:0] exp_addr_q [$];
  logic [31:0] exp_strb_q [$];

  int   cur_id;
  int   cur_nexp;
  int   beats_seen;
  int   done_seen;
  int   res_out;
  int   res_ret;
  int   strb_out;
  int   strb_ret;
  int   res_delay;
  int   strb_delay;
  int   err_cnt;
  logic withhold;

  tb_clock_gen u_clk (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  masku_top dut_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .done_valid_o  (done_valid_o),
    .done_id_o     (done_id_o),
    .opa_i         (opa_i),
    .opa_valid_i   (opa_valid_i),
    .opa_ready_o   (opa_ready_o),
    .opb_i         (opb_i),
    .opb_valid_i   (opb_valid_i),
    .opb_ready_o   (opb_ready_o),
    .opm_i         (opm_i),
    .opm_valid_i   (opm_valid_i),
    .opm_ready_o   (opm_ready_o),
    .res_valid_o   (res_valid_o),
    .res_id_o      (res_id_o),
    .res_addr_o    (res_addr_o),
    .res_wdata_o   (res_wdata_o),
    .res_credit_i  (res_credit_i),
    .strb_valid_o  (strb_valid_o),
    .strb_o        (strb_o),
    .strb_credit_i (strb_credit_i)
  );

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      err_cnt++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "stopped at first error");
  endtask

  // Holds the current driven values until the chosen ready is seen
  task automatic wait_accept(input int which);
    logic fired;
    fired = 1'b0;
    while (!fired) begin
      #1;
      fired = (which == 0) ? req_ready_o : (which == 1) ? opa_ready_o : opm_ready_o;
      // b always goes with a, m only when the merge is masked
      if (which == 1 && fired) begin
        check("opb_ready with opa", 32'd1, 32'(opb_ready_o));
        check("opm_ready with opa", 32'(!req_i.vm), 32'(opm_ready_o));
      end
      @(negedge clk_i);
    end
  endtask

  //////////////////////////////////////////////////
  // Output monitor and credit return
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin : p_monitor
    res_credit_i  = 1'b0;
    strb_credit_i = 1'b0;
    if (rst_ni && res_valid_o) begin
      if (exp_word_q.size() == 0) begin
        fail_run("A result beat came out when none was expected");
      end else begin
        check("result word", exp_word_q.pop_front(), 32'(res_wdata_o));
        check("result addr", exp_addr_q.pop_front(), 32'(res_addr_o));
        check("result id", 32'(cur_id), 32'(res_id_o));
        beats_seen++;
        res_out++;
        check("result beats without credit", 32'd1,
              32'((res_out - res_ret) <= `MASKU_CREDITS));
      end
    end
    if (rst_ni && strb_valid_o) begin
      if (exp_strb_q.size() == 0) begin
        fail_run("A strobe beat came out when none was expected");
      end else begin
        check("strobe beat", exp_strb_q.pop_front(), 32'(strb_o));
        beats_seen++;
        strb_out++;
        check("strobe beats without credit", 32'd1,
              32'((strb_out - strb_ret) <= `MASKU_CREDITS));
      end
    end
    if (rst_ni && done_valid_o) begin
      check("done id", 32'(cur_id), 32'(done_id_o));
      // All beats must have left before completion
      check("beats before done", 32'(cur_nexp), 32'(beats_seen));
      done_seen++;
    end
    // Consumers hand credits back after a random delay
    if (!withhold && res_out > res_ret) begin
      if (res_delay == 0) begin
        res_credit_i = 1'b1;
        res_ret++;
        res_delay = $urandom % 4;
      end else begin
        res_delay--;
      end
    end
    if (!withhold && strb_out > strb_ret) begin
      if (strb_delay == 0) begin
        strb_credit_i = 1'b1;
        strb_ret++;
        strb_delay = $urandom % 4;
      end else begin
        strb_delay--;
      end
    end
  end

  // Watchdog
  initial begin
    repeat (NLINES * 200) @(posedge clk_i);
    fail_run("Timeout, the DUT did not finish all instructions in time");
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic run_line(input int ln);
    logic [31:0] f [NFIELDS];
    logic        is_dist;
    for (int i = 0; i < NFIELDS; i++) begin
      f[i] = golden[ln*NFIELDS + i];
    end
    is_dist = f[0][0];
    // Withheld credits start from an empty pipeline
    if (f[11] > `MASKU_CREDITS) begin
      while (res_out != res_ret || strb_out != strb_ret) @(negedge clk_i);
      #1;
      withhold = 1'b1;
    end
    cur_id     = int'(f[5]);
    cur_nexp   = int'(f[11]);
    beats_seen = 0;
    done_seen  = 0;
    for (int k = 0; k < cur_nexp; k++) begin
      if (is_dist) begin
        exp_strb_q.push_back(f[12+k]);
      end else begin
        exp_word_q.push_back(f[12+k]);
        // Two register-file words per vector register
        exp_addr_q.push_back(f[4] * 2 + 32'(k));
      end
    end
    @(negedge clk_i);
    req_i.op    = masku_pkg::mask_op_e'(f[0][0]);
    req_i.vm    = f[1][0];
    req_i.sew   = masku_pkg::sew_e'(f[2][0]);
    req_i.vl    = masku_pkg::vl_t'(f[3]);
    req_i.vd    = masku_pkg::vaddr_t'(f[4]);
    req_i.id    = masku_pkg::vid_t'(f[5]);
    req_valid_i = 1'b1;
    wait_accept(0);
    req_valid_i = 1'b0;
    fork
      begin
        if (is_dist) begin
          repeat ($urandom % 3) @(negedge clk_i);
          opm_i       = f[10];
          opm_valid_i = 1'b1;
          wait_accept(2);
          opm_valid_i = 1'b0;
        end else begin
          for (int k = 0; k < cur_nexp; k++) begin
            repeat ($urandom % 3) @(negedge clk_i);
            opa_i       = f[6+k];
            opb_i       = f[8+k];
            opm_i       = f[10];
            opa_valid_i = 1'b1;
            opb_valid_i = 1'b1;
            opm_valid_i = !f[1][0];
            wait_accept(1);
            opa_valid_i = 1'b0;
            opb_valid_i = 1'b0;
            opm_valid_i = 1'b0;
          end
        end
      end
      begin
        if (withhold) begin
          repeat (HOLD_CYCLES) @(negedge clk_i);
          #1;
          check("beats sent while credits withheld", `MASKU_CREDITS, 32'(beats_seen));
          withhold = 1'b0;
        end
      end
    join
    // Unit stays busy until the done pulse
    while (done_seen == 0) begin
      @(negedge clk_i);
      #2;
      if (done_seen == 0) begin
        check("req_ready while busy", 32'd0, 32'(req_ready_o));
      end
    end
    @(negedge clk_i);
    #2;
    check("done pulses per instruction", 32'd1, 32'(done_seen));
    check("ready after done", 32'd1, 32'(req_ready_o));
  endtask

  initial begin
    void'($urandom(21));
    req_i = '0;
    req_valid_i = 1'b0;
    opa_i = '0;
    opb_i = '0;
    opm_i = '0;
    opa_valid_i = 1'b0;
    opb_valid_i = 1'b0;
    opm_valid_i = 1'b0;
    res_credit_i = 1'b0;
    strb_credit_i = 1'b0;
    withhold = 1'b0;
    err_cnt = 0;
    res_out = 0;
    res_ret = 0;
    strb_out = 0;
    strb_ret = 0;
    res_delay = 0;
    strb_delay = 0;
    $readmemh("masku_golden.mem", golden);
    @(posedge rst_ni);
    @(negedge clk_i);
    #1;
    check("reset req_ready", 32'd1, 32'(req_ready_o));
    check("reset res_valid", 32'd0, 32'(res_valid_o));
    check("reset strb_valid", 32'd0, 32'(strb_valid_o));
    check("reset done_valid", 32'd0, 32'(done_valid_o));
    for (int ln = 0; ln < NLINES; ln++) begin
      run_line(ln);
    end
    repeat (4) @(negedge clk_i);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- masku_golden.mem
// op vm sew vl vd id | a0 a1 b0 b1 m | beats | expected words or strobes e0..e7
// op 0 merge, 1 distribution; sew 0 EW8, 1 EW16; all values hex
// Unmasked merge, two beats, vl 40
0 1 0 28 03 1 FFFFFFFF FFFFFFFF 00000000 00000000 00000000 2
FFFFFFFF 000000FF 0 0 0 0 0 0
// Unmasked merge, one beat, vl 20
0 1 0 14 05 2 12345678 00000000 AAAAAAAA 00000000 00000000 1
AAA45678 0 0 0 0 0 0 0
// Masked merge, full vl
0 0 0 40 01 3 FFFFFFFF 0F0F0F0F 00000000 F0F0F0F0 0000FFFF 2
0000FFFF F0F00F0F 0 0 0 0 0 0
// Masked merge, vl 12
0 0 0 0C 00 0 5555AAAA 00000000 FFFF0000 00000000 000000F0 1
FFFF00A0 0 0 0 0 0 0 0
// Distribution EW8 unmasked, vl 10
1 1 0 0A 00 1 00000000 00000000 00000000 00000000 00000000 3
F F 3 0 0 0 0 0
// Distribution EW8 masked, vl 16
1 0 0 10 00 2 00000000 00000000 00000000 00000000 0000A5C3 4
3 C 5 A 0 0 0 0
// Distribution EW16 unmasked, vl 5
1 1 1 05 00 3 00000000 00000000 00000000 00000000 00000000 3
F F 3 0 0 0 0 0
// Distribution EW16 masked, vl 12
1 0 1 0C 00 0 00000000 00000000 00000000 00000000 00000E5B 6
F C 3 3 C F 0 0
// Long distribution for back-pressure, EW8 vl 32
1 1 0 20 00 1 00000000 00000000 00000000 00000000 00000000 8
F F F F F F F F

//--- filelist.f
+incdir+.
masku_pkg.sv
masku_ctrl.sv
mask_merge_alu.sv
mask_strobe_expander.sv
credit_queue.sv
masku_top.sv
tb_clock_gen.sv
tb_masku.sv

//--- Makefile
# Verilator build and run for the mask unit testbench

.PHONY: compile run clean

compile:
	verilator --binary --assert --top-module tb_masku -f filelist.f -Mdir obj_dir

run: compile
	./obj_dir/Vtb_masku | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
